// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // geometry
    localparam int word_w      = 32;   // data and address width
    localparam int block_words = 2;    // words per line
    localparam int n_ways      = 2;
    localparam int n_sets      = 16;   // 16 sets x 2 ways x 8 bytes = 256 bytes

    // address split: tag | set | word | byte
    localparam int set_bits   = 4;
    localparam int block_bits = 1;
    localparam int tag_bits   = word_w - set_bits - block_bits - 2;

    localparam int cnt_w = 16;  // hit and miss counters

    // everything from here up is uncached after reset
    localparam logic [word_w-1:0] noncache_reset = 32'h8000_0000;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,        // refill from memory
        st_wb,           // victim write-back
        st_uncached,     // single word pass-through
        st_flush_scan,   // look for next dirty line
        st_flush_line    // write back one dirty line
    } cache_state_t;

    // register word index
    typedef enum logic [2:0] {
        reg_noncache = 3'd0,
        reg_ctrl     = 3'd1,
        reg_status   = 3'd2,
        reg_hits     = 3'd3,
        reg_misses   = 3'd4
    } reg_sel_t;

endpackage

`default_nettype wire

// ==== logic/l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
    input  logic                          cif,
    input  logic                          arst_n,
    // processor side
    input  logic [cache_pkg::word_w-1:0]  proc_addr,
    input  logic [cache_pkg::word_w-1:0]  proc_wdata,
    input  logic                          proc_ren,
    input  logic                          proc_wen,
    output logic [cache_pkg::word_w-1:0]  proc_rdata,
    output logic                          proc_busy,
    // memory side, cache is master
    output logic [cache_pkg::word_w-1:0]  mem_addr,
    output logic [cache_pkg::word_w-1:0]  mem_wdata,
    output logic                          mem_ren,
    output logic                          mem_wen,
    input  logic [cache_pkg::word_w-1:0]  mem_rdata,
    input  logic                          mem_busy,
    // register block
    input  logic [cache_pkg::word_w-1:0]  noncache_base,
    input  logic                          flush_pending,
    output logic                          flush_done,
    output logic                          hit_pulse,
    output logic                          miss_pulse
);
    import cache_pkg::*;

    cache_state_t state, state_nxt;

    // address fields, byte bits ignored
    logic [tag_bits-1:0]   addr_tag;
    logic [set_bits-1:0]   addr_set;
    logic [block_bits-1:0] addr_word;

    assign addr_tag  = proc_addr[word_w-1 -: tag_bits];
    assign addr_set  = proc_addr[2+block_bits +: set_bits];
    assign addr_word = proc_addr[2 +: block_bits];

    // storage
    logic [word_w-1:0]   data_arr  [n_sets][n_ways][block_words];
    logic [tag_bits-1:0] tag_arr   [n_sets][n_ways];
    logic [n_ways-1:0]   valid_arr [n_sets];
    logic [n_ways-1:0]   dirty_arr [n_sets];
    logic                lru_arr   [n_sets];  // way used last

    // counters
    logic [block_bits-1:0] word_cnt;
    logic [set_bits-1:0]   set_cnt;   // flush walk
    logic                  way_cnt;
    logic                  miss_seen; // current access already missed once

    logic [n_ways-1:0] way_hit;
    logic              hit_way;
    logic              hit;
    logic              req;
    logic              uncached;
    logic              victim;
    logic              victim_dirty;
    logic              last_word;
    logic              fl_dirty;
    logic              flush_last;
    logic              hit_done;    // processor access served from the array
    logic              wr_hit;
    logic              fill_we;     // fetched word arrives
    logic              fill_done;
    logic              word_step;
    logic              line_step;
    logic              flush_clean;

    // tag compare, both ways in parallel
    always_comb begin
        for (int w = 0; w < n_ways; w++) begin
            way_hit[w] = valid_arr[addr_set][w] && (tag_arr[addr_set][w] == addr_tag);
        end
    end

    assign req          = proc_ren | proc_wen;
    assign uncached     = (proc_addr >= noncache_base);
    assign hit          = (|way_hit) & ~uncached;
    assign hit_way      = way_hit[1];           // only meaningful with hit
    assign victim       = ~lru_arr[addr_set];   // evict the other way
    assign victim_dirty = valid_arr[addr_set][victim] & dirty_arr[addr_set][victim];

    assign last_word  = (word_cnt == block_bits'(block_words - 1));
    assign fl_dirty   = valid_arr[set_cnt][way_cnt] & dirty_arr[set_cnt][way_cnt];
    assign flush_last = (set_cnt == set_bits'(n_sets - 1)) && (way_cnt == 1'(n_ways - 1));

    assign hit_done    = (state == st_idle) && req && hit;
    assign wr_hit      = hit_done && proc_wen;
    assign fill_we     = (state == st_fetch) && !mem_busy;
    assign fill_done   = fill_we && last_word;
    assign flush_clean = (state == st_flush_line) && !mem_busy && last_word;
    assign line_step   = (state == st_flush_scan) && !fl_dirty;
    assign word_step   = !mem_busy &&
                         (state == st_fetch || state == st_wb || state == st_flush_line);

    // next state and bus outputs
    always_comb begin
        state_nxt  = state;
        proc_busy  = 1'b1;
        proc_rdata = data_arr[addr_set][hit_way][addr_word];
        mem_addr   = {addr_tag, addr_set, word_cnt, 2'b00};   // refill address
        mem_wdata  = data_arr[addr_set][victim][word_cnt];
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        flush_done = 1'b0;
        hit_pulse  = 1'b0;
        miss_pulse = 1'b0;

        case (state)
            st_idle: begin
                if (req && uncached) begin
                    state_nxt = st_uncached;
                end else if (req && hit) begin
                    proc_busy  = 1'b0;
                    // a refilled access is counted as the miss it was
                    hit_pulse  = ~miss_seen;
                    miss_pulse = miss_seen;
                end else if (req) begin
                    state_nxt = victim_dirty ? st_wb : st_fetch;
                end else if (flush_pending) begin
                    state_nxt = st_flush_scan;
                end
            end

            st_fetch: begin
                mem_ren = 1'b1;
                if (fill_done) begin
                    state_nxt = st_idle;  // access then hits
                end
            end

            st_wb: begin
                mem_wen  = 1'b1;
                mem_addr = {tag_arr[addr_set][victim], addr_set, word_cnt, 2'b00}; // old line
                if (!mem_busy && last_word) begin
                    state_nxt = st_fetch;
                end
            end

            st_uncached: begin
                // straight pass-through of one word
                mem_ren    = proc_ren;
                mem_wen    = proc_wen;
                mem_addr   = proc_addr;
                mem_wdata  = proc_wdata;
                proc_rdata = mem_rdata;
                proc_busy  = mem_busy;
                if (!mem_busy) begin
                    state_nxt = st_idle;
                end
            end

            st_flush_scan: begin
                if (fl_dirty) begin
                    state_nxt = st_flush_line;
                end else if (flush_last) begin
                    flush_done = 1'b1;
                    state_nxt  = st_idle;
                end
            end

            st_flush_line: begin
                mem_wen   = 1'b1;
                mem_addr  = {tag_arr[set_cnt][way_cnt], set_cnt, word_cnt, 2'b00};
                mem_wdata = data_arr[set_cnt][way_cnt][word_cnt];
                if (flush_clean) begin
                    state_nxt = st_flush_scan;  // rescan sees it clean and moves on
                end
            end

            default: state_nxt = st_idle;
        endcase
    end

    // state, counters
    always_ff @(posedge cif or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            word_cnt  <= '0;
            set_cnt   <= '0;
            way_cnt   <= 1'b0;
            miss_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (word_step) begin
                word_cnt <= word_cnt + 1'b1;  // wraps at line end
            end
            if (line_step) begin
                {set_cnt, way_cnt} <= {set_cnt, way_cnt} + 1'b1; // wraps to 0 after last line
            end
            if (state == st_idle && req && !uncached) begin
                miss_seen <= ~hit;
            end
        end
    end

    // line status
    always_ff @(posedge cif or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < n_sets; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
                lru_arr[s]   <= 1'b0;
            end
        end else begin
            if (hit_done) begin
                lru_arr[addr_set] <= hit_way;
            end
            if (wr_hit) begin
                dirty_arr[addr_set][hit_way] <= 1'b1;
            end
            if (fill_done) begin
                valid_arr[addr_set][victim] <= 1'b1;
                dirty_arr[addr_set][victim] <= 1'b0;
            end
            if (flush_clean) begin
                dirty_arr[set_cnt][way_cnt] <= 1'b0;  // stays valid
            end
        end
    end

    // data and tags
    always_ff @(posedge cif) begin
        if (wr_hit) begin
            data_arr[addr_set][hit_way][addr_word] <= proc_wdata;
        end
        if (fill_we) begin
            data_arr[addr_set][victim][word_cnt] <= mem_rdata;
        end
        if (fill_done) begin
            tag_arr[addr_set][victim] <= addr_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_regs (
    input  logic                          cif,
    input  logic                          arst_n,
    input  cache_pkg::reg_sel_t           reg_sel,
    input  logic [cache_pkg::word_w-1:0]  reg_wdata,
    input  logic                          reg_wen,
    input  logic                          flush_done,
    input  logic                          hit_pulse,
    input  logic                          miss_pulse,
    output logic [cache_pkg::word_w-1:0]  reg_rdata,
    output logic [cache_pkg::word_w-1:0]  noncache_base,
    output logic                          flush_pending
);
    import cache_pkg::*;

    logic             done_sticky;  // set by flush_done, cleared by new command
    logic [cnt_w-1:0] hit_cnt;
    logic [cnt_w-1:0] miss_cnt;
    logic             ctrl_wr;

    // saturating increment
    function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    assign ctrl_wr = reg_wen && (reg_sel == reg_ctrl);

    always_ff @(posedge cif or negedge arst_n) begin
        if (!arst_n) begin
            noncache_base <= noncache_reset;
            flush_pending <= 1'b0;
            done_sticky   <= 1'b0;
            hit_cnt       <= '0;
            miss_cnt      <= '0;
        end else begin
            if (reg_wen && reg_sel == reg_noncache) begin
                noncache_base <= reg_wdata;
            end

            // new command wins over a finishing flush
            if (ctrl_wr && reg_wdata[0]) begin
                flush_pending <= 1'b1;
                done_sticky   <= 1'b0;
            end else if (flush_done) begin
                flush_pending <= 1'b0;
                done_sticky   <= 1'b1;
            end

            if (ctrl_wr && reg_wdata[1]) begin  // counter clear
                hit_cnt  <= '0;
                miss_cnt <= '0;
            end else begin
                if (hit_pulse)  hit_cnt  <= sat_inc(hit_cnt);
                if (miss_pulse) miss_cnt <= sat_inc(miss_cnt);
            end
        end
    end

    // read mux
    always_comb begin
        case (reg_sel)
            reg_noncache: reg_rdata = noncache_base;
            reg_status:   reg_rdata = word_w'({done_sticky, flush_pending});
            reg_hits:     reg_rdata = word_w'(hit_cnt);
            reg_misses:   reg_rdata = word_w'(miss_cnt);
            default:      reg_rdata = '0;  // ctrl bits act on write only
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
    input  logic                          cif,
    input  logic                          arst_n,
    // processor bus
    input  logic [cache_pkg::word_w-1:0]  proc_addr,
    input  logic [cache_pkg::word_w-1:0]  proc_wdata,
    input  logic                          proc_ren,
    input  logic                          proc_wen,
    output logic [cache_pkg::word_w-1:0]  proc_rdata,
    output logic                          proc_busy,
    // memory bus
    output logic [cache_pkg::word_w-1:0]  mem_addr,
    output logic [cache_pkg::word_w-1:0]  mem_wdata,
    output logic                          mem_ren,
    output logic                          mem_wen,
    input  logic [cache_pkg::word_w-1:0]  mem_rdata,
    input  logic                          mem_busy,
    // register bus
    input  cache_pkg::reg_sel_t           reg_sel,
    input  logic [cache_pkg::word_w-1:0]  reg_wdata,
    input  logic                          reg_wen,
    output logic [cache_pkg::word_w-1:0]  reg_rdata
);
    import cache_pkg::*;

    // between cache and register block
    logic [word_w-1:0] noncache_base;
    logic              flush_pending;   // level
    logic              flush_done;      // one-cycle pulse
    logic              hit_pulse;
    logic              miss_pulse;

    l1_cache u_cache (
        .cif           (cif),
        .arst_n        (arst_n),
        .proc_addr     (proc_addr),
        .proc_wdata    (proc_wdata),
        .proc_ren      (proc_ren),
        .proc_wen      (proc_wen),
        .proc_rdata    (proc_rdata),
        .proc_busy     (proc_busy),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_ren       (mem_ren),
        .mem_wen       (mem_wen),
        .mem_rdata     (mem_rdata),
        .mem_busy      (mem_busy),
        .noncache_base (noncache_base),
        .flush_pending (flush_pending),
        .flush_done    (flush_done),
        .hit_pulse     (hit_pulse),
        .miss_pulse    (miss_pulse)
    );

    cache_regs u_regs (
        .cif           (cif),
        .arst_n        (arst_n),
        .reg_sel       (reg_sel),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen),
        .flush_done    (flush_done),
        .hit_pulse     (hit_pulse),
        .miss_pulse    (miss_pulse),
        .reg_rdata     (reg_rdata),
        .noncache_base (noncache_base),
        .flush_pending (flush_pending)
    );

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic        cif,
    input  logic        arst_n,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        ren,
    input  logic        wen,
    output logic [31:0] rdata,
    output logic        busy
);
    localparam int mem_wait = 2;     // wait cycles per word
    localparam int depth    = 2048;  // 8 KB, byte addresses 0 to 1FFF

    logic [31:0] mem [depth];
    logic        req;
    logic [10:0] idx;
    int          cnt;                // wait cycles seen for current word

    // same preload rule as the testbench shadow
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[11'(i)] <= fill_word(i * 4);
        end
    end

    assign req   = ren | wen;
    assign idx   = addr[12:2];                   // word index, upper bits ignored
    assign busy  = !(req && cnt == mem_wait);    // low for one cycle per word
    assign rdata = mem[idx];

    always_ff @(posedge cif or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= 0;
        end else if (!req || cnt == mem_wait) begin
            cnt <= 0;          // next word starts over
        end else begin
            cnt <= cnt + 1;
        end
    end

    // write lands at the edge where busy is low
    always @(posedge cif) begin
        if (wen && !busy) begin
            mem[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== tb/cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_sva (
    input logic                         cif,
    input logic                         arst_n,
    input logic                         proc_busy,
    input logic                         mem_ren,
    input logic                         mem_wen,
    input logic [cache_pkg::word_w-1:0] mem_addr,
    input logic [cache_pkg::word_w-1:0] mem_wdata,
    input logic                         mem_busy,
    input logic                         flush_done
);

    // one direction at a time on the memory bus
    mem_excl: assert property (@(posedge cif) disable iff (!arst_n)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high in the same cycle");

    flush_pulse: assert property (@(posedge cif) disable iff (!arst_n)
        flush_done |=> !flush_done)
        else $error("flush_done longer than one cycle");

    // request held until memory drops busy
    mem_hold: assert property (@(posedge cif) disable iff (!arst_n)
        (mem_ren || mem_wen) && mem_busy |=>
            $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed while mem_busy high");

    busy_after_reset: assert property (@(posedge cif)
        $rose(arst_n) |-> proc_busy)
        else $error("proc_busy low right after reset");

endmodule

bind l1_cache cache_sva u_sva (
    .cif        (cif),
    .arst_n     (arst_n),
    .proc_busy  (proc_busy),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_busy   (mem_busy),
    .flush_done (flush_done)
);

`default_nettype wire

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int mem_wait        = 2;    // as in mem_model
    localparam int word_cycles     = mem_wait + 1;
    localparam int miss_cycles     = 3 + 4 * word_cycles;  // write-back, refill, final hit
    localparam int uncached_cycles = 3 + word_cycles;
    localparam int flush_cycles    = 2 + n_sets * n_ways * (2 + 2 * word_cycles);
    localparam int n_cached        = 220;  // cached accesses over all tests, rounded up
    localparam int n_uncached      = 80;
    localparam int n_flush         = 2;
    localparam int n_reg           = 40;   // register accesses outside flush polling
    localparam int watchdog_cycles = 2 * (3 + n_cached * miss_cycles
                                          + n_uncached * uncached_cycles
                                          + n_flush * flush_cycles + 2 * n_reg);
    localparam logic [31:0] uc_base = 32'h0000_1000;

    logic              cif;
    logic              arst_n;
    logic [word_w-1:0] proc_addr;
    logic [word_w-1:0] proc_wdata;
    logic              proc_ren;
    logic              proc_wen;
    logic [word_w-1:0] proc_rdata;
    logic              proc_busy;
    logic [word_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic              mem_ren;
    logic              mem_wen;
    logic [word_w-1:0] mem_rdata;
    logic              mem_busy;
    reg_sel_t          reg_sel;
    logic [word_w-1:0] reg_wdata;
    logic              reg_wen;
    logic [word_w-1:0] reg_rdata;

    logic [31:0] shadow [2048];  // expected memory as the processor should see it
    int          errors;
    int          checks;
    int          exp_hits;
    int          exp_misses;

    cache_subsystem UUT (
        .cif        (cif),
        .arst_n     (arst_n),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_ren   (proc_ren),
        .proc_wen   (proc_wen),
        .proc_rdata (proc_rdata),
        .proc_busy  (proc_busy),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy),
        .reg_sel    (reg_sel),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .reg_rdata  (reg_rdata)
    );

    mem_model u_mem (
        .cif    (cif),
        .arst_n (arst_n),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .ren    (mem_ren),
        .wen    (mem_wen),
        .rdata  (mem_rdata),
        .busy   (mem_busy)
    );

    initial begin
        cif = 1'b0;
        forever #20 cif = ~cif;  // 40 ns
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;  // every address bit matters
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", what, got, exp);
            errors++;
        end
    endtask

    // called 5 ns after an edge, returns 5 ns after the completing edge
    task automatic proc_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited     = 0;
        proc_addr  = addr;
        proc_wdata = wdata;
        proc_ren   = ~wr;
        proc_wen   = wr;
        @(negedge cif);
        while (proc_busy && waited < 2 * miss_cycles) begin
            @(negedge cif);  // settled mid cycle
            waited++;
        end
        if (proc_busy) begin
            $display("processor access to %h never completed", addr);
            errors++;
        end
        rdata = proc_rdata;
        @(posedge cif);
        #5;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] v;
        proc_access(1'b0, addr, 32'h0, v);
        check_word($sformatf("proc_rdata @%h", addr), v, shadow[addr[12:2]]);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd_ignored;
        proc_access(1'b1, addr, data, rd_ignored);
        shadow[addr[12:2]] = data;
    endtask

    task automatic reg_write(input reg_sel_t sel, input logic [31:0] data);
        reg_sel   = sel;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(posedge cif);
        #5;
        reg_wen = 1'b0;
    endtask

    task automatic reg_read(input reg_sel_t sel, output logic [31:0] data);
        reg_sel = sel;
        @(negedge cif);
        data = reg_rdata;  // combinational read
        @(posedge cif);
        #5;
    endtask

    task automatic set_base(input logic [31:0] base);
        reg_write(reg_noncache, base);
    endtask

    task automatic check_counters();
        logic [31:0] v;
        reg_read(reg_hits, v);
        check_word("reg_rdata hits", v, exp_hits);
        reg_read(reg_misses, v);
        check_word("reg_rdata misses", v, exp_misses);
    endtask

    // command a flush and poll status until done
    task automatic run_flush();
        logic [31:0] st;
        int          polls;
        reg_write(reg_ctrl, 32'h1);
        polls = 0;
        st    = 32'h0;
        while (!st[1] && polls < flush_cycles) begin
            reg_read(reg_status, st);
            polls++;
        end
        if (!st[1]) begin
            $display("flush never reported done");
            errors++;
        end
        check_word("reg_rdata status", st, 32'h2);  // done, nothing pending
    endtask

    task automatic reset_values();
        logic [31:0] v;
        reg_read(reg_noncache, v);
        check_word("reg_rdata noncache", v, 32'h8000_0000);
        reg_read(reg_status, v);
        check_word("reg_rdata status", v, 32'h0);
        check_counters();
    endtask

    task automatic read_miss_then_hit();
        read_check(32'h0000_0100);   // cold line
        exp_misses++;
        check_counters();
        read_check(32'h0000_0100);
        read_check(32'h0000_0104);   // other word, same line
        exp_hits += 2;
        check_counters();
    endtask

    task automatic dirty_eviction();
        write_word(32'h0000_0100, $urandom());  // hit, line now dirty
        exp_hits++;
        read_check(32'h0000_0180);   // set 0, new tag
        read_check(32'h0000_0200);   // set 0 again, LRU victim is the dirty line
        exp_misses += 2;
        set_base(32'h0);             // everything uncached
        read_check(32'h0000_0100);   // memory must hold the written word
        set_base(noncache_reset);
        read_check(32'h0000_0100);   // reload
        read_check(32'h0000_0104);
        exp_misses++;
        exp_hits++;
        check_counters();
    endtask

    task automatic uncached_path();
        logic [31:0] w;
        set_base(uc_base);
        w = $urandom();
        write_word(32'h0000_1040, w);
        check_word("u_mem.mem @00001040", u_mem.mem[11'h410], w);
        read_check(32'h0000_1040);
        read_check(32'h0000_1044);
        check_counters();            // untouched by uncached accesses
    endtask

    task automatic flush_lines();
        logic [31:0] lines [$];
        lines = '{32'h0000_0300, 32'h0000_0318, 32'h0000_0328, 32'h0000_033C};
        foreach (lines[i]) begin
            write_word(lines[i], $urandom());  // write allocate, sets 0 3 5 7
        end
        exp_misses += 4;
        run_flush();
        set_base(32'h0);
        foreach (lines[i]) begin
            read_check(lines[i]);
        end
        set_base(uc_base);
        read_check(32'h0000_0318);   // flushed line stays valid
        exp_hits++;
        check_counters();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [5:0]  idx;
        logic [31:0] addr;
        logic [31:0] h;
        logic [31:0] m;
        reg_write(reg_ctrl, 32'h2);  // clear counters
        repeat (200) begin
            r    = $urandom();
            idx  = r[5:0];
            // 8 tags over 4 sets, plenty of evictions
            addr = 32'h400 + {22'h0, idx[5:3], 2'b00, idx[2:0], 2'b00};
            if (r[8]) begin
                write_word(addr, $urandom());
            end else begin
                read_check(addr);
            end
        end
        run_flush();
        set_base(32'h0);
        for (int i = 0; i < 64; i++) begin
            idx  = 6'(i);
            addr = 32'h400 + {22'h0, idx[5:3], 2'b00, idx[2:0], 2'b00};
            read_check(addr);
        end
        set_base(uc_base);
        reg_read(reg_hits, h);
        reg_read(reg_misses, m);
        check_word("reg_rdata hits+misses", h + m, 32'd200);
    endtask

    initial begin
        void'($urandom(88316));
        errors     = 0;
        checks     = 0;
        exp_hits   = 0;
        exp_misses = 0;
        arst_n     = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        reg_sel    = reg_noncache;
        reg_wdata  = '0;
        reg_wen    = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            shadow[11'(i)] = fill_word(i * 4);
        end
        repeat (3) @(posedge cif);
        #5;
        arst_n = 1'b1;
        @(posedge cif);
        #5;
        reset_values();
        read_miss_then_hit();
        dirty_eviction();
        uncached_path();
        flush_lines();
        random_mix();
        $display("checks %0d  errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // twice the summed worst case of all tests
    initial begin
        repeat (watchdog_cycles) @(posedge cif);
        $display("watchdog expired after %0d cycles, simulation stuck", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/cache_pkg.sv
logic/l1_cache.sv
logic/cache_regs.sv
logic/cache_subsystem.sv
tb/mem_model.sv
tb/cache_sva.sv
tb/cache_tb.sv

// ==== Makefile ====
TOP := cache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
